// ==== src/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath width of the accumulator and data memory
`define CPU_WORD_BITS 16

// Address width of each memory, 256 words apiece
`define CPU_ADDR_BITS 8

// Receiver buffer depth, also the credit count after reset
`define CPU_OUT_CREDITS 4

`endif

// ==== src/isa_pkg.sv ====
package isa_pkg;

    // Full 4-bit opcode space, no undefined codes
    typedef enum logic [3:0] {
        op_load  = 4'h0,  // acc = dmem[addr]
        op_store = 4'h1,  // dmem[addr] = acc
        op_loadi = 4'h2,  // acc = zero-extended operand
        op_add   = 4'h3,  // acc = acc + dmem[addr]
        op_sub   = 4'h4,  // acc = acc - dmem[addr]
        op_and   = 4'h5,  // Bitwise with memory word
        op_or    = 4'h6,
        op_xor   = 4'h7,
        op_shl   = 4'h8,  // Shift left by one, zero fill
        op_shr   = 4'h9,  // Shift right by one, zero fill
        op_rol   = 4'ha,  // Rotate left by one
        op_jump  = 4'hb,  // PC = addr
        op_skipz = 4'hc,  // Skip next when acc is zero
        op_skipn = 4'hd,  // Skip next when acc is negative
        op_out   = 4'he,  // Send acc on output stream
        op_halt  = 4'hf   // Stop and raise halted
    } opcode_e;

    // One instruction word, opcode in the top nibble
    typedef struct packed {
        opcode_e     op;
        logic [11:0] operand;  // Address or immediate
    } instr_t;

endpackage

// ==== src/port_pkg.sv ====
`include "cpu_settings.svh"

package port_pkg;

    // Host write into either memory while idle
    typedef struct packed {
        logic                      valid;
        logic                      to_data;  // 1 = data memory, 0 = instruction memory
        logic [`CPU_ADDR_BITS-1:0] addr;
        logic [`CPU_WORD_BITS-1:0] data;
    } load_req_t;

    // One beat of the OUT stream
    typedef struct packed {
        logic                      valid;
        logic [`CPU_WORD_BITS-1:0] data;
    } out_beat_t;

    // Next-PC choice made by the sequencer
    typedef enum logic [1:0] {
        pc_step = 2'd0,  // PC + 1
        pc_skip = 2'd1,  // PC + 2
        pc_jump = 2'd2,  // Operand address
        pc_hold = 2'd3   // Unchanged
    } pc_action_e;

endpackage

// ==== src/word_memory.sv ====
`include "cpu_settings.svh"

module word_memory #(
    parameter type payload_t = logic [`CPU_WORD_BITS-1:0]  // Stored word type
) (
    input  logic                      clock,
    input  logic                      write_en,
    input  logic [`CPU_ADDR_BITS-1:0] write_addr,
    input  payload_t                  write_data,
    input  logic                      read_en,
    input  logic [`CPU_ADDR_BITS-1:0] read_addr,
    output payload_t                  read_data
);

    localparam int mem_depth = 1 << `CPU_ADDR_BITS;  // Full address space

    payload_t mem [mem_depth];  // Contents start unknown

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[write_addr] <= write_data;  // Lands on this edge
        end
        if (read_en) begin
            read_data <= mem[read_addr];  // Valid next cycle, old data on collision
        end
    end

    // An enabled port with an unknown address would corrupt or return garbage
    write_addr_known: assert property (
        @(posedge clock) write_en |-> !$isunknown(write_addr)
    ) else $error("word_memory write with unknown address");

    read_addr_known: assert property (
        @(posedge clock) read_en |-> !$isunknown(read_addr)
    ) else $error("word_memory read with unknown address");

endmodule

// ==== src/fetch_unit.sv ====
`include "cpu_settings.svh"

module fetch_unit
    import isa_pkg::*;
    import port_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  load_req_t  load,
    input  logic       fetch_req,
    input  pc_action_e pc_action,
    output instr_t     instr
);

    logic [`CPU_ADDR_BITS-1:0] pc;            // Program counter
    logic [`CPU_ADDR_BITS-1:0] jump_target;   // Low bits of operand
    logic                      imem_write_en;  // Host load aimed at this memory

    assign imem_write_en = load.valid && !load.to_data;
    assign jump_target   = instr.operand[`CPU_ADDR_BITS-1:0];  // Held instr of current op

    word_memory #(
        .payload_t(instr_t)
    ) u_imem (
        .clock      (clock),
        .write_en   (imem_write_en),
        .write_addr (load.addr),
        .write_data (instr_t'(load.data)),  // Raw word reinterpreted as instruction
        .read_en    (fetch_req),
        .read_addr  (pc),
        .read_data  (instr)                 // Holds between fetches
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0;  // Every run begins at address 0
        end else begin
            case (pc_action)
                pc_step: pc <= pc + 1'b1;  // Wraps at address width
                pc_skip: pc <= pc + 2'd2;
                pc_jump: pc <= jump_target;
                default: pc <= pc;         // Hold
            endcase
        end
    end

    // Host writes only happen while idle, so never alongside a fetch
    load_not_during_fetch: assert property (
        @(posedge clock) disable iff (reset)
        fetch_req |-> !imem_write_en
    ) else $error("instruction load collides with fetch");

    // Instruction word is valid on the cycle after each fetch
    instr_known_after_fetch: assert property (
        @(posedge clock) disable iff (reset)
        fetch_req |=> !$isunknown(instr.op)
    ) else $error("fetched an unloaded instruction word");

endmodule

// ==== src/alu.sv ====
`include "cpu_settings.svh"

module alu
    import isa_pkg::*;
(
    input  opcode_e                   op,
    input  logic [`CPU_WORD_BITS-1:0] acc,      // Current accumulator
    input  logic [`CPU_WORD_BITS-1:0] operand,  // Memory word or immediate
    output logic [`CPU_WORD_BITS-1:0] result    // Next accumulator
);

    localparam int msb = `CPU_WORD_BITS - 1;  // Sign bit position

    always_comb begin
        case (op)
            op_load, op_loadi: begin
                result = operand;  // Straight load
            end
            op_add: begin
                result = acc + operand;  // Wraps modulo 2^16
            end
            op_sub: begin
                result = acc - operand;  // Wraps modulo 2^16
            end
            op_and: begin
                result = acc & operand;
            end
            op_or: begin
                result = acc | operand;
            end
            op_xor: begin
                result = acc ^ operand;
            end
            op_shl: begin
                result = {acc[msb-1:0], 1'b0};  // Zero into bit 0
            end
            op_shr: begin
                result = {1'b0, acc[msb:1]};  // Logical, zero into sign bit
            end
            op_rol: begin
                result = {acc[msb-1:0], acc[msb]};  // Sign bit wraps to bit 0
            end
            default: begin
                result = acc;  // Store, control and OUT keep acc
            end
        endcase
    end

endmodule

// ==== src/sequencer.sv ====
`include "cpu_settings.svh"

module sequencer
    import isa_pkg::*;
    import port_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  load_req_t                 load,
    input  instr_t                    instr,
    output logic                      fetch_req,
    output pc_action_e                pc_action,
    output logic                      dmem_read_en,
    output logic [`CPU_ADDR_BITS-1:0] dmem_read_addr,
    input  logic [`CPU_WORD_BITS-1:0] dmem_read_data,
    output logic                      dmem_write_en,
    output logic [`CPU_ADDR_BITS-1:0] dmem_write_addr,
    output logic [`CPU_WORD_BITS-1:0] dmem_write_data,
    output out_beat_t                 out,
    input  logic                      credit_return,
    output logic                      busy,
    output logic                      halted
);

    localparam int credit_bits = $clog2(`CPU_OUT_CREDITS + 1);  // Holds 0..full

    typedef enum logic [2:0] {
        st_idle,      // Waiting for start
        st_fetch,     // Read instruction at PC
        st_decode,    // Instruction valid, issue data read
        st_mem_wait,  // Data word arriving
        st_execute    // Update acc, PC, memory or output
    } state_e;

    state_e                    state;
    logic [`CPU_WORD_BITS-1:0] acc;
    logic [`CPU_WORD_BITS-1:0] alu_operand;  // Memory word or immediate
    logic [`CPU_WORD_BITS-1:0] alu_result;
    logic [credit_bits-1:0]    credits;      // Free slots at the receiver
    logic                      needs_read;   // Opcode reads a data word
    logic                      in_execute;
    logic                      send_beat;    // OUT with a credit available
    logic                      stalled;      // OUT with no credit
    logic                      store_now;

    assign needs_read = instr.op inside {op_load, op_add, op_sub, op_and, op_or, op_xor};
    assign in_execute = (state == st_execute);
    assign send_beat  = in_execute && (instr.op == op_out) && (credits != '0);
    assign stalled    = in_execute && (instr.op == op_out) && (credits == '0);
    assign store_now  = in_execute && (instr.op == op_store);
    assign busy       = (state != st_idle);
    assign fetch_req  = (state == st_fetch);

    assign alu_operand = (instr.op == op_loadi) ? `CPU_WORD_BITS'(instr.operand)
                                                : dmem_read_data;  // Zero-extend immediate

    alu u_alu (
        .op      (instr.op),
        .acc     (acc),
        .operand (alu_operand),
        .result  (alu_result)
    );

    // Data read issued in decode and held by memory through execute
    assign dmem_read_en   = (state == st_decode) && needs_read;
    assign dmem_read_addr = instr.operand[`CPU_ADDR_BITS-1:0];

    // STORE while running or host loads while idle
    assign dmem_write_en   = store_now || (!busy && load.valid && load.to_data);
    assign dmem_write_addr = busy ? instr.operand[`CPU_ADDR_BITS-1:0] : load.addr;
    assign dmem_write_data = busy ? acc : load.data;

    assign out.valid = send_beat;
    assign out.data  = acc;

    always_comb begin
        pc_action = pc_hold;  // PC moves only at end of execute
        if (in_execute) begin
            case (instr.op)
                op_jump:  pc_action = pc_jump;
                op_skipz: pc_action = (acc == '0) ? pc_skip : pc_step;
                op_skipn: pc_action = acc[`CPU_WORD_BITS-1] ? pc_skip : pc_step;
                op_out:   pc_action = stalled ? pc_hold : pc_step;
                op_halt:  pc_action = pc_hold;
                default:  pc_action = pc_step;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state  <= st_idle;
            acc    <= '0;
            halted <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state  <= st_fetch;  // Fetch unit clears PC on same edge
                        halted <= 1'b0;
                    end
                end
                st_fetch:    state <= st_decode;
                st_decode:   state <= needs_read ? st_mem_wait : st_execute;
                st_mem_wait: state <= st_execute;
                default: begin  // Execute
                    acc <= alu_result;  // Unchanged for non-acc opcodes
                    if (instr.op == op_halt) begin
                        state  <= st_idle;
                        halted <= 1'b1;
                    end else if (!stalled) begin
                        state <= st_fetch;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits <= credit_bits'(`CPU_OUT_CREDITS);  // Receiver starts empty
        end else if (send_beat && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (credit_return && !send_beat) begin
            credits <= credits + 1'b1;
        end
    end

    credit_bound: assert property (
        @(posedge clock) disable iff (reset)
        credits <= `CPU_OUT_CREDITS
    ) else $error("receiver returned more credits than it owns");

    load_while_idle: assert property (
        @(posedge clock) disable iff (reset)
        busy |-> !load.valid
    ) else $error("host load while running");

endmodule

// ==== src/accum_cpu.sv ====
`include "cpu_settings.svh"

module accum_cpu
    import isa_pkg::*;
    import port_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      start,          // One-cycle pulse while idle
    input  load_req_t load,           // Host memory writes
    output out_beat_t out,            // OUT stream
    input  logic      credit_return,  // One credit per high cycle
    output logic      busy,
    output logic      halted
);

    instr_t                    instr;  // Current instruction word
    logic                      fetch_req;
    pc_action_e                pc_action;
    logic                      dmem_read_en;
    logic [`CPU_ADDR_BITS-1:0] dmem_read_addr;
    logic [`CPU_WORD_BITS-1:0] dmem_read_data;
    logic                      dmem_write_en;
    logic [`CPU_ADDR_BITS-1:0] dmem_write_addr;
    logic [`CPU_WORD_BITS-1:0] dmem_write_data;

    fetch_unit u_fetch (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .load      (load),
        .fetch_req (fetch_req),
        .pc_action (pc_action),
        .instr     (instr)
    );

    word_memory #(
        .payload_t(logic [`CPU_WORD_BITS-1:0])  // Plain data words
    ) u_dmem (
        .clock      (clock),
        .write_en   (dmem_write_en),
        .write_addr (dmem_write_addr),
        .write_data (dmem_write_data),
        .read_en    (dmem_read_en),
        .read_addr  (dmem_read_addr),
        .read_data  (dmem_read_data)
    );

    sequencer u_seq (
        .clock           (clock),
        .reset           (reset),
        .start           (start),
        .load            (load),
        .instr           (instr),
        .fetch_req       (fetch_req),
        .pc_action       (pc_action),
        .dmem_read_en    (dmem_read_en),
        .dmem_read_addr  (dmem_read_addr),
        .dmem_read_data  (dmem_read_data),
        .dmem_write_en   (dmem_write_en),
        .dmem_write_addr (dmem_write_addr),
        .dmem_write_data (dmem_write_data),
        .out             (out),
        .credit_return   (credit_return),
        .busy            (busy),
        .halted          (halted)
    );

endmodule

// ==== verif/accum_cpu_tb.sv ====
`include "cpu_settings.svh"

module accum_cpu_tb
    import isa_pkg::*;
    import port_pkg::*;
();

    localparam int timeout_cycles = 1000;  // Limit for every wait loop

    typedef struct {
        string                     name;
        opcode_e                   op;
        logic [`CPU_WORD_BITS-1:0] a;  // Data word 0 loaded first
        logic [`CPU_WORD_BITS-1:0] b;  // Data word 1 as the op's operand
    } alu_row_t;

    logic      clock = 1'b0;
    logic      reset;
    logic      start;
    load_req_t load;
    out_beat_t out;
    logic      credit_return = 1'b0;
    logic      busy;
    logic      halted;

    logic                      credit_en = 1'b1;  // Receiver frees slots when high
    int                        beats_seen;
    int                        credits_given;
    logic [`CPU_WORD_BITS-1:0] beats [$];         // Words taken off the out stream
    logic [`CPU_WORD_BITS-1:0] expected [$];
    logic [`CPU_WORD_BITS-1:0] prog [$];          // Instruction image from address 0
    logic [`CPU_WORD_BITS-1:0] data_words [$];    // Data image from address 0
    alu_row_t                  rows [$];
    logic [31:0]               rng = 32'he903_8388;
    int                        errors = 0;
    int                        timeouts = 0;

    accum_cpu u_dut (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .load          (load),
        .out           (out),
        .credit_return (credit_return),
        .busy          (busy),
        .halted        (halted)
    );

    always #4 clock = ~clock;

    // Receiver buffer with one entry per beat
    always @(negedge clock) begin
        if (reset) begin
            beats.delete();
            beats_seen <= 0;
        end else if (out.valid) begin
            beats.push_back(out.data);
            beats_seen <= beats_seen + 1;
        end
    end

    // One credit back per beat received while released
    always @(posedge clock) begin
        if (reset) begin
            credit_return <= 1'b0;
            credits_given <= 0;
        end else if (credit_en && credits_given < beats_seen) begin
            credit_return <= 1'b1;
            credits_given <= credits_given + 1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected accumulator after one instruction
    function automatic logic [15:0] model_alu(opcode_e op, logic [15:0] acc,
                                              logic [15:0] word, logic [11:0] imm);
        case (op)
            op_load:  return word;
            op_loadi: return {4'h0, imm};  // Zero-extended immediate
            op_add:   return acc + word;
            op_sub:   return acc - word;
            op_and:   return acc & word;
            op_or:    return acc | word;
            op_xor:   return acc ^ word;
            op_shl:   return acc << 1;
            op_shr:   return acc >> 1;
            op_rol:   return (acc << 1) | (acc >> 15);  // Top bit comes back at bit 0
            default:  return acc;
        endcase
    endfunction

    task automatic add_instr(opcode_e op, logic [11:0] operand);
        prog.push_back({op, operand});  // Opcode in top nibble
    endtask

    task automatic add_row(opcode_e op, logic [15:0] a, logic [15:0] b);
        alu_row_t row;
        row.name = $sformatf("%s_%0d", op.name(), rows.size());
        row.op   = op;
        row.a    = a;
        row.b    = b;
        rows.push_back(row);
    endtask

    task automatic clear_case();
        prog.delete();
        data_words.delete();
        expected.delete();
    endtask

    task automatic reset_dut();
        @(posedge clock);
        reset     <= 1'b1;
        credit_en <= 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
    endtask

    task automatic write_word(logic to_data, logic [`CPU_ADDR_BITS-1:0] addr,
                              logic [`CPU_WORD_BITS-1:0] data);
        @(posedge clock);
        load <= '{valid: 1'b1, to_data: to_data, addr: addr, data: data};
        @(posedge clock);
        load <= '0;
    endtask

    task automatic load_and_start();
        foreach (prog[i]) write_word(1'b0, `CPU_ADDR_BITS'(i), prog[i]);
        foreach (data_words[i]) write_word(1'b1, `CPU_ADDR_BITS'(i), data_words[i]);
        @(posedge clock);
        start <= 1'b1;  // Single-cycle pulse
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic wait_halted(string name);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!halted && cycles < timeout_cycles) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            $display("%s: timed out waiting for halted", name);
            timeouts++;
        end
    endtask

    task automatic wait_beats(string name, int count);
        int cycles;
        cycles = 0;
        while (beats_seen < count && cycles < timeout_cycles) begin
            @(negedge clock);
            cycles++;
        end
        if (beats_seen < count) begin
            $display("%s: timed out waiting for %0d output beats", name, count);
            timeouts++;
        end
    endtask

    task automatic check_beats(string name);
        @(posedge clock);  // Buffer settled since the last beat
        if (beats.size() != expected.size()) begin
            $display("error %s: beat count expected %0d actual %0d",
                     name, expected.size(), beats.size());
            errors++;
        end
        foreach (expected[i]) begin
            if (i < beats.size() && beats[i] !== expected[i]) begin
                $display("error %s: beat %0d expected %h actual %h",
                         name, i, expected[i], beats[i]);
                errors++;
            end
        end
    endtask

    task automatic run_case(string name);
        reset_dut();
        load_and_start();
        wait_halted(name);
        check_beats(name);
    endtask

    initial begin
        opcode_e     alu_ops [10];
        logic [11:0] imm;
        reset   = 1'b1;
        start   = 1'b0;
        load    = '0;
        alu_ops = '{op_load, op_loadi, op_add, op_sub, op_and,
                    op_or, op_xor, op_shl, op_shr, op_rol};

        reset_dut();
        @(negedge clock);
        if (busy || halted || out.valid) begin
            $display("error reset_state: busy,halted,valid expected 000 actual %b%b%b",
                     busy, halted, out.valid);
            errors++;
        end
        clear_case();
        add_instr(op_halt, 12'h000);
        run_case("halt_only");  // No beats expected

        foreach (alu_ops[k]) begin
            add_row(alu_ops[k], 16'h0000, 16'hFFFF);
            add_row(alu_ops[k], 16'hFFFF, 16'h8000);
            add_row(alu_ops[k], 16'h8000, 16'h8000);
            repeat (2) begin
                rng = xorshift(rng);
                add_row(alu_ops[k], rng[31:16], rng[15:0]);
            end
        end
        foreach (rows[r]) begin
            clear_case();
            add_instr(op_load, 12'h000);
            add_instr(rows[r].op, 12'h001);  // Shifts ignore the operand
            add_instr(op_out, 12'h000);
            add_instr(op_halt, 12'h000);
            data_words.push_back(rows[r].a);
            data_words.push_back(rows[r].b);
            expected.push_back(model_alu(rows[r].op, rows[r].a, rows[r].b, 12'h001));
            run_case(rows[r].name);
        end

        rng = xorshift(rng);
        imm = rng[11:0];
        clear_case();
        add_instr(op_loadi, imm);
        add_instr(op_store, 12'h005);
        add_instr(op_loadi, 12'h000);  // Wipe acc before reload
        add_instr(op_load, 12'h005);
        add_instr(op_out, 12'h000);
        add_instr(op_halt, 12'h000);
        expected.push_back({4'h0, imm});
        run_case("store_loadi");

        // Each skipped OUT would leave a wrong word in the beat stream
        clear_case();
        add_instr(op_loadi, 12'h011);
        add_instr(op_jump, 12'h003);
        add_instr(op_out, 12'h000);    // Jumped over
        add_instr(op_out, 12'h000);
        add_instr(op_loadi, 12'h000);
        add_instr(op_skipz, 12'h000);  // Taken
        add_instr(op_out, 12'h000);
        add_instr(op_loadi, 12'h022);
        add_instr(op_skipz, 12'h000);  // Not taken
        add_instr(op_out, 12'h000);
        add_instr(op_load, 12'h000);   // acc = 8000
        add_instr(op_skipn, 12'h000);  // Taken
        add_instr(op_out, 12'h000);
        add_instr(op_loadi, 12'h033);
        add_instr(op_skipn, 12'h000);  // Not taken
        add_instr(op_out, 12'h000);
        add_instr(op_halt, 12'h000);
        data_words.push_back(16'h8000);
        expected.push_back(16'h0011);
        expected.push_back(16'h0022);
        expected.push_back(16'h0033);
        run_case("control_flow");

        clear_case();
        for (int k = 0; k < 6; k++) begin
            add_instr(op_loadi, 12'h100 + 12'(k * 17));
            add_instr(op_out, 12'h000);
            expected.push_back(16'h0100 + 16'(k * 17));
        end
        add_instr(op_halt, 12'h000);
        reset_dut();
        credit_en <= 1'b0;  // Receiver holds every slot
        load_and_start();
        wait_beats("credit_stall", `CPU_OUT_CREDITS);
        repeat (40) @(negedge clock);  // Window for any beat past the credits
        if (beats_seen > `CPU_OUT_CREDITS) begin
            $display("error credit_stall: beats at most %0d actual %0d",
                     `CPU_OUT_CREDITS, beats_seen);
            errors++;
        end
        if (!busy || halted) begin
            $display("error credit_stall: busy,halted expected 10 actual %b%b", busy, halted);
            errors++;
        end
        @(posedge clock);
        credit_en <= 1'b1;
        wait_halted("credit_release");
        check_beats("credit_release");

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/isa_pkg.sv
src/port_pkg.sv
src/word_memory.sv
src/fetch_unit.sv
src/alu.sv
src/sequencer.sv
src/accum_cpu.sv
verif/accum_cpu_tb.sv

// ==== Makefile ====
TOP = accum_cpu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" sim.log; then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
